// ==== include/fetch_cfg.svh ====
`ifndef FETCH_CFG_SVH
`define FETCH_CFG_SVH

// address and data width of the fetch path
`define FETCH_XLEN 32

// first word fetched after reset
`define FETCH_RESET_PC 32'h8000_0000

// sequential pc step, no compressed words
`define FETCH_INST_BYTES 4

`endif

// ==== logic/rv_isa_pkg.sv ====
`default_nettype none

package rv_isa_pkg;

    // major opcodes seen by the front end
    localparam logic [6:0] OPC_OP   = 7'b0110011;
    localparam logic [6:0] OPC_JAL  = 7'b1101111;
    localparam logic [6:0] OPC_JALR = 7'b1100111;

    // funct7 of the RV32M group
    localparam logic [6:0] F7_MULDIV = 7'b0000001;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_type_t;

    // immediate bits in encoding order, offset bit 0 is implied
    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_type_t;

    // one fetched word, read as R or J format
    typedef union packed {
        r_type_t r;
        j_type_t j;
    } inst_u;

endpackage

`default_nettype wire

// ==== logic/fetch_pkg.sv ====
`default_nettype none

`include "fetch_cfg.svh"

package fetch_pkg;

    typedef logic [`FETCH_XLEN-1:0] pc_t;

    // one fetch in flight: request, wait for the word, settle
    typedef enum logic [1:0] {
        F_IDLE = 2'd0,
        F_WAIT = 2'd1,
        F_DONE = 2'd2
    } fetch_state_t;

    // fetch stalls waiting on execute
    typedef enum logic [1:0] {
        H_NONE   = 2'd0,
        H_MULDIV = 2'd1,
        H_JALR   = 2'd2
    } hold_state_t;

endpackage

`default_nettype wire

// ==== logic/fetch_req_if.sv ====
`default_nettype none

`include "fetch_cfg.svh"

interface fetch_req_if;
    import fetch_pkg::*;

    logic                   req_valid;
    pc_t                    req_pc;
    // single-cycle pulses from the bus side
    logic                   req_hs;
    logic                   done;
    logic [`FETCH_XLEN-1:0] data;

    modport pcgen (
        output req_valid, req_pc,
        input  req_hs, done, data
    );

    modport bus (
        input  req_valid, req_pc,
        output req_hs, done, data
    );

endinterface

`default_nettype wire

// ==== logic/predecode_if.sv ====
`default_nettype none

interface predecode_if;
    import fetch_pkg::*;

    // only meaningful while done is high
    logic is_muldiv;
    logic is_jal;
    logic is_jalr;
    pc_t  jal_target;

    modport source (output is_muldiv, is_jal, is_jalr, jal_target);

    modport sink (input is_muldiv, is_jal, is_jalr, jal_target);

endinterface

`default_nettype wire

// ==== logic/pc_predict.sv ====
`default_nettype none

`include "fetch_cfg.svh"

module pc_predict (
    input  logic           clk,
    input  logic           rst_n,
    fetch_req_if.pcgen     fetch,
    predecode_if.sink      pre,
    input  logic           muldiv_done,
    input  logic           jalr_valid,
    input  fetch_pkg::pc_t jalr_target,
    input  logic           redirect_valid,
    input  fetch_pkg::pc_t redirect_pc,
    output logic           redirect_ready
);
    import fetch_pkg::*;

    localparam pc_t INST_BYTES = pc_t'(`FETCH_INST_BYTES);

    fetch_state_t state_q;
    fetch_state_t state_d;
    hold_state_t  hold_q;
    hold_state_t  hold_d;
    pc_t          pc_q;
    pc_t          pc_d;
    logic         req_valid_q;
    logic         redirect_hs;

    // redirect only while nothing is requested or held
    assign redirect_ready = (state_q == F_IDLE) && (hold_q == H_NONE) && !req_valid_q;
    assign redirect_hs    = redirect_valid && redirect_ready;

    assign fetch.req_valid = req_valid_q;
    assign fetch.req_pc    = pc_q;

    always_comb begin
        state_d = state_q;
        case (state_q)
            F_IDLE: begin
                if (fetch.req_hs) begin
                    state_d = F_WAIT;
                end
            end
            F_WAIT: begin
                if (fetch.done) begin
                    state_d = F_DONE;
                end
            end
            F_DONE: state_d = F_IDLE;
            default: state_d = F_IDLE;
        endcase
    end

    // next pc and hold; pc_q stays the pc of the word in flight until done
    always_comb begin
        hold_d = hold_q;
        pc_d   = pc_q;
        if (fetch.done) begin
            if (pre.is_muldiv) begin
                pc_d   = pc_q + INST_BYTES;
                hold_d = H_MULDIV;
            end else if (pre.is_jal) begin
                pc_d = pre.jal_target;
            end else if (pre.is_jalr) begin
                hold_d = H_JALR;
            end else begin
                pc_d = pc_q + INST_BYTES;
            end
        end else if (hold_q == H_MULDIV && muldiv_done) begin
            hold_d = H_NONE;
        end else if (hold_q == H_JALR && jalr_valid) begin
            hold_d = H_NONE;
            pc_d   = jalr_target;
        end else if (redirect_hs) begin
            pc_d = redirect_pc;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= F_IDLE;
            hold_q  <= H_NONE;
            pc_q    <= `FETCH_RESET_PC;
        end else begin
            state_q <= state_d;
            hold_q  <= hold_d;
            pc_q    <= pc_d;
        end
    end

    // a redirect takes the slot a new request would have used
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            req_valid_q <= 1'b0;
        end else if (fetch.req_hs) begin
            req_valid_q <= 1'b0;
        end else if (state_q != F_WAIT && hold_q == H_NONE && !redirect_hs) begin
            req_valid_q <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== logic/inst_predecode.sv ====
`default_nettype none

`include "fetch_cfg.svh"

module inst_predecode (
    input  fetch_pkg::pc_t     fetch_pc,
    input  rv_isa_pkg::inst_u  word,
    predecode_if.source        pre
);
    import fetch_pkg::*;
    import rv_isa_pkg::*;

    pc_t j_offset;

    // RV32M lives in the OP major opcode with its own funct7
    assign pre.is_muldiv = (word.r.opcode == OPC_OP) && (word.r.funct7 == F7_MULDIV);

    assign pre.is_jal  = (word.j.opcode == OPC_JAL);
    assign pre.is_jalr = (word.r.opcode == OPC_JALR);

    // J immediate, sign from bit 31, always even
    assign j_offset = {
        {(`FETCH_XLEN-20){word.j.imm20}},
        word.j.imm19_12,
        word.j.imm11,
        word.j.imm10_1,
        1'b0
    };

    // predicted target, taken as soon as the word is accepted
    assign pre.jal_target = fetch_pc + j_offset;

endmodule

`default_nettype wire

// ==== logic/fetch_axi_master.sv ====
`default_nettype none

`include "fetch_cfg.svh"

module fetch_axi_master (
    input  logic                   clk,
    input  logic                   rst_n,
    fetch_req_if.bus               fetch,
    output logic                   ar_valid,
    input  logic                   ar_ready,
    output fetch_pkg::pc_t         ar_addr,
    input  logic                   r_valid,
    output logic                   r_ready,
    input  logic [`FETCH_XLEN-1:0] r_data,
    output logic                   inst_valid,
    input  logic                   inst_ready,
    output logic [`FETCH_XLEN-1:0] inst_data,
    output fetch_pkg::pc_t         inst_pc
);
    logic start;

    // new request only once the previous word has left
    assign start = !ar_valid && !r_ready && !inst_valid && fetch.req_valid;

    assign fetch.req_hs = ar_valid && ar_ready;
    assign fetch.done   = inst_valid && inst_ready;
    assign fetch.data   = inst_data;

    // AR, then R, then hold the word for decode
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ar_valid   <= 1'b0;
            r_ready    <= 1'b0;
            inst_valid <= 1'b0;
        end else if (inst_valid) begin
            if (inst_ready) begin
                inst_valid <= 1'b0;
            end
        end else if (r_ready) begin
            if (r_valid) begin
                r_ready    <= 1'b0;
                inst_valid <= 1'b1;
            end
        end else if (ar_valid) begin
            if (ar_ready) begin
                ar_valid <= 1'b0;
                r_ready  <= 1'b1;
            end
        end else if (start) begin
            ar_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            ar_addr <= fetch.req_pc;
        end
        if (r_valid && r_ready) begin
            inst_data <= r_data;
            inst_pc   <= ar_addr;
        end
    end

endmodule

`default_nettype wire

// ==== logic/fetch_frontend.sv ====
`default_nettype none

`include "fetch_cfg.svh"

module fetch_frontend (
    input  logic                   clk,
    input  logic                   rst_n,
    output logic                   ar_valid,
    input  logic                   ar_ready,
    output fetch_pkg::pc_t         ar_addr,
    input  logic                   r_valid,
    output logic                   r_ready,
    input  logic [`FETCH_XLEN-1:0] r_data,
    output logic                   inst_valid,
    input  logic                   inst_ready,
    output logic [`FETCH_XLEN-1:0] inst_data,
    output fetch_pkg::pc_t         inst_pc,
    input  logic                   redirect_valid,
    output logic                   redirect_ready,
    input  fetch_pkg::pc_t         redirect_pc,
    input  logic                   muldiv_done,
    input  logic                   jalr_valid,
    input  fetch_pkg::pc_t         jalr_target
);
    fetch_req_if fetch_if ();
    predecode_if pre_if ();

    pc_predict u_pc_predict (
        .clk            (clk),
        .rst_n          (rst_n),
        .fetch          (fetch_if.pcgen),
        .pre            (pre_if.sink),
        .muldiv_done    (muldiv_done),
        .jalr_valid     (jalr_valid),
        .jalr_target    (jalr_target),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .redirect_ready (redirect_ready)
    );

    // fetch_if.data is the buffered decode word
    inst_predecode u_inst_predecode (
        .fetch_pc (inst_pc),
        .word     (fetch_if.data),
        .pre      (pre_if.source)
    );

    fetch_axi_master u_fetch_axi_master (
        .clk        (clk),
        .rst_n      (rst_n),
        .fetch      (fetch_if.bus),
        .ar_valid   (ar_valid),
        .ar_ready   (ar_ready),
        .ar_addr    (ar_addr),
        .r_valid    (r_valid),
        .r_ready    (r_ready),
        .r_data     (r_data),
        .inst_valid (inst_valid),
        .inst_ready (inst_ready),
        .inst_data  (inst_data),
        .inst_pc    (inst_pc)
    );

endmodule

`default_nettype wire

// ==== testbench/tb_axi_mem.sv ====
`default_nettype none

`include "fetch_cfg.svh"

module tb_axi_mem #(
    parameter logic [31:0] seed_init = 32'h9a3abaeb
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   ar_valid,
    output logic                   ar_ready,
    input  logic [`FETCH_XLEN-1:0] ar_addr,
    output logic                   r_valid,
    input  logic                   r_ready,
    output logic [`FETCH_XLEN-1:0] r_data
);
    timeunit 1ns;
    timeprecision 1ps;

    logic [31:0] image [0:255];
    logic [31:0] addr_q;
    logic [31:0] r;
    logic [20:0] off;
    logic [1:0]  wait_cnt;
    logic        busy;
    integer      seed;
    integer      i;

    // random program of OP, RV32M, short JAL and JALR words
    initial begin
        ar_ready = 1'b0;
        r_valid  = 1'b0;
        r_data   = '0;
        wait_cnt = 2'd0;
        busy     = 1'b0;
        seed     = seed_init;
        for (i = 0; i < 256; i++) begin
            r   = $random(seed);
            off = 21'(({17'd0, r[6:3]} + 21'd1) << 2);
            if (r[7]) begin
                off = -off;
            end
            case (r[2:0])
                3'd0: image[i] = {7'b0000001, r[25:8], 7'b0110011};
                3'd1: image[i] = {off[20], off[10:1], off[11], off[19:12], r[12:8], 7'b1101111};
                3'd2: image[i] = {r[31:15], 3'b000, r[11:7], 7'b1100111};
                default: image[i] = {7'b0000000, r[25:8], 7'b0110011};
            endcase
        end
    end

    // one read at a time, each phase delayed 0 to 3 cycles
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ar_ready <= 1'b0;
            r_valid  <= 1'b0;
            busy     <= 1'b0;
            wait_cnt <= 2'd0;
        end else if (ar_ready) begin
            ar_ready <= 1'b0;
            busy     <= 1'b1;
            addr_q   <= ar_addr;
            wait_cnt <= 2'($random(seed));
        end else if (r_valid && r_ready) begin
            r_valid  <= 1'b0;
            busy     <= 1'b0;
            wait_cnt <= 2'($random(seed));
        end else if (wait_cnt != 2'd0) begin
            wait_cnt <= wait_cnt - 2'd1;
        end else if (busy && !r_valid) begin
            r_valid <= 1'b1;
            r_data  <= image[addr_q[9:2]];
        end else if (!busy && ar_valid) begin
            ar_ready <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== testbench/tb_fetch_frontend.sv ====
`default_nettype none

`include "fetch_cfg.svh"

module tb_fetch_frontend;
    timeunit 1ns;
    timeprecision 1ps;
    import fetch_pkg::*;

    localparam int          n_tests        = 8;
    localparam int          words_per_test = 32;
    localparam logic [31:0] seed_init      = 32'h9a3abaeb;

    logic                   clk;
    logic                   rst_n;
    logic                   ar_valid;
    logic                   ar_ready;
    pc_t                    ar_addr;
    logic                   r_valid;
    logic                   r_ready;
    logic [`FETCH_XLEN-1:0] r_data;
    logic                   inst_valid;
    logic                   inst_ready;
    logic [`FETCH_XLEN-1:0] inst_data;
    pc_t                    inst_pc;
    logic                   redirect_valid;
    logic                   redirect_ready;
    pc_t                    redirect_pc;
    logic                   muldiv_done;
    logic                   jalr_valid;
    pc_t                    jalr_target;

    integer                 seed;
    int                     test;
    int                     words;
    int                     redirects;
    int                     checks;
    int                     errors;
    // reference model of the pc and the hold
    pc_t                    exp_pc;
    pc_t                    flight_pc;
    hold_state_t            exp_hold;
    logic                   redirect_hs;
    // R phase open between the AR and R handshakes
    logic                   reading;
    // decode word left waiting at the last sample
    logic                   stalled;
    logic [`FETCH_XLEN-1:0] stalled_data;
    pc_t                    stalled_pc;

    fetch_frontend uut (.*);

    tb_axi_mem #(.seed_init(seed_init)) u_mem (.*);

    // J immediate as laid out in the base ISA
    function automatic pc_t jal_offset(input logic [31:0] w);
        return {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
    endfunction

    function automatic pc_t random_pc();
        return `FETCH_RESET_PC + ((pc_t'($random(seed)) & 32'h3ff) << 2);
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("CHECK FAILED at %0t: %s expected %h got %h",
                     $time, name, expected, actual);
        end
    endtask

    task automatic drive_inputs();
        inst_ready  <= (($random(seed) & 3) != 0);
        muldiv_done <= (($random(seed) & 7) == 0);
        jalr_valid  <= (($random(seed) & 7) == 0);
        jalr_target <= random_pc();
        // a redirect stays offered until it is taken
        if (!redirect_valid || redirect_hs) begin
            redirect_valid <= (test > 0) && (($random(seed) & 7) == 0);
            redirect_pc    <= random_pc();
        end
    endtask

    task automatic sample_and_model();
        logic [31:0] w;
        if (stalled) begin
            check_value("inst_valid", 1, inst_valid);
            check_value("inst_data", stalled_data, inst_data);
            check_value("inst_pc", stalled_pc, inst_pc);
        end
        stalled      = inst_valid && !inst_ready;
        stalled_data = inst_data;
        stalled_pc   = inst_pc;
        if (exp_hold != H_NONE) begin
            check_value("ar_valid", 0, ar_valid);
            check_value("redirect_ready", 0, redirect_ready);
        end
        check_value("r_ready", reading, r_ready);
        if (r_valid && r_ready) begin
            reading = 1'b0;
        end
        if (ar_valid && ar_ready) begin
            check_value("ar_addr", exp_pc, ar_addr);
            flight_pc = exp_pc;
            reading   = 1'b1;
        end
        redirect_hs = redirect_valid && redirect_ready;
        if (inst_valid && inst_ready) begin
            w = u_mem.image[flight_pc[9:2]];
            check_value("inst_pc", flight_pc, inst_pc);
            check_value("inst_data", w, inst_data);
            words++;
            if (w[6:0] == 7'h33 && w[31:25] == 7'h01) begin
                exp_pc   = flight_pc + `FETCH_INST_BYTES;
                exp_hold = H_MULDIV;
            end else if (w[6:0] == 7'h6f) begin
                exp_pc = flight_pc + jal_offset(w);
            end else if (w[6:0] == 7'h67) begin
                exp_hold = H_JALR;
            end else begin
                exp_pc = flight_pc + `FETCH_INST_BYTES;
            end
        end else if (exp_hold == H_MULDIV && muldiv_done) begin
            exp_hold = H_NONE;
        end else if (exp_hold == H_JALR && jalr_valid) begin
            exp_hold = H_NONE;
            exp_pc   = jalr_target;
        end else if (redirect_hs) begin
            exp_pc = redirect_pc;
            redirects++;
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        repeat (n_tests * words_per_test * 40) @(posedge clk);
        $display("timeout: the front end stopped handing words to decode");
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin
        seed           = seed_init;
        rst_n          = 1'b0;
        inst_ready     = 1'b0;
        redirect_valid = 1'b0;
        redirect_pc    = '0;
        muldiv_done    = 1'b0;
        jalr_valid     = 1'b0;
        jalr_target    = '0;
        test           = 0;
        checks         = 0;
        errors         = 0;
        exp_pc         = `FETCH_RESET_PC;
        exp_hold       = H_NONE;
        flight_pc      = '0;
        redirect_hs    = 1'b0;
        reading        = 1'b0;
        stalled        = 1'b0;
        repeat (8) @(posedge clk);
        check_value("ar_valid", 0, ar_valid);
        check_value("inst_valid", 0, inst_valid);
        rst_n <= 1'b1;
        for (test = 0; test < n_tests; test++) begin
            words     = 0;
            redirects = 0;
            while (words < words_per_test) begin
                @(posedge clk);
                drive_inputs();
                @(negedge clk);
                sample_and_model();
            end
            $display("test %0d: %0d words, %0d redirects, %0d errors so far",
                     test, words, redirects, errors);
        end
        $display("%0d tests, %0d checks, %0d errors", n_tests, checks, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+include
logic/rv_isa_pkg.sv
logic/fetch_pkg.sv
logic/fetch_req_if.sv
logic/predecode_if.sv
logic/pc_predict.sv
logic/inst_predecode.sv
logic/fetch_axi_master.sv
logic/fetch_frontend.sv
testbench/tb_axi_mem.sv
testbench/tb_fetch_frontend.sv

// ==== Bender.yml ====
package:
  name: fetch_frontend

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - logic/rv_isa_pkg.sv
      - logic/fetch_pkg.sv
      - logic/fetch_req_if.sv
      - logic/predecode_if.sv
      - logic/pc_predict.sv
      - logic/inst_predecode.sv
      - logic/fetch_axi_master.sv
      - logic/fetch_frontend.sv
  - target: test
    include_dirs:
      - include
    files:
      - testbench/tb_axi_mem.sv
      - testbench/tb_fetch_frontend.sv
